/* hw/rv32_isa_pkg.sv */
// RV32 ISA level types for the execute stage
// data word, register index, CSR address, ALU and branch encodings
// implemented CSR addresses and the pc step
package rv32_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  // integer operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_t;

  // branch compares, same values as funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_func_t;

  // machine mode CSRs held in the local file
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;

  localparam int NUM_CSR = 4;

  // byte step between sequential instructions
  localparam word_t WORD_BYTES = 32'd4;

endpackage

/* hw/ex_pipe_pkg.sv */
// execute pipeline encodings
// write-back source select, jalr target mask, commit bubble values
package ex_pipe_pkg;

  import rv32_isa_pkg::*;

  // where the written-back value comes from
  typedef enum logic [1:0] {
    SRC_ALU  = 2'd0,
    SRC_LINK = 2'd1,
    SRC_CSR  = 2'd2
  } result_src_t;

  // jalr drops the low target bit
  localparam word_t JALR_ALIGN_MASK = 32'hffff_fffe;

  // contents of an empty commit slot
  localparam word_t     BUBBLE_WORD   = 32'h0000_0000;
  localparam reg_addr_t BUBBLE_REG_RD = 5'd0;
  localparam logic      BUBBLE_FLAG   = 1'b0;

endpackage

/* hw/alu_unit.sv */
// integer ALU for the execute stage
// operation result and write-back value select
module alu_unit
  import rv32_isa_pkg::*;
  import ex_pipe_pkg::*;
(
  input  word_t       port_a,
  input  word_t       port_b,
  input  word_t       pc,
  input  alu_op_t     alu_op,
  input  result_src_t result_src,
  input  word_t       csr_rdata,
  output word_t       alu_wdata
);

  word_t      alu_result;
  logic [4:0] shamt;

  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = port_a + port_b;
      ALU_SUB:  alu_result = port_a - port_b;
      ALU_AND:  alu_result = port_a & port_b;
      ALU_OR:   alu_result = port_a | port_b;
      ALU_XOR:  alu_result = port_a ^ port_b;
      ALU_SLT:  alu_result = {31'b0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: alu_result = {31'b0, port_a < port_b};
      ALU_SLL:  alu_result = port_a << shamt;
      ALU_SRL:  alu_result = port_a >> shamt;
      ALU_SRA:  alu_result = $signed(port_a) >>> shamt;
      default:  alu_result = '0;
    endcase
  end

  // link value for jal/jalr, old CSR value for csr reads
  always_comb begin
    case (result_src)
      SRC_LINK: alu_wdata = pc + WORD_BYTES;
      SRC_CSR:  alu_wdata = csr_rdata;
      default:  alu_wdata = alu_result;
    endcase
  end

endmodule

/* hw/branch_resolver.sv */
// branch and jump resolution
// compare, targets, mispredict detect, redirect address, registered mispredict
module branch_resolver
  import rv32_isa_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  word_t        port_a,
  input  word_t        port_b,
  input  word_t        immediate,
  input  word_t        pc,
  input  logic         branch_instr,
  input  branch_func_t branch_func,
  input  logic         prediction,
  input  logic         jump_instr,
  input  logic         jalr,
  output logic         branch_taken,
  output logic         mispredict,
  output logic         mispredict_ff,
  output word_t        resolved_addr,
  output word_t        jump_addr,
  output word_t        brj_addr
);

  word_t pc4;
  word_t branch_addr;
  logic  branch_mispredict;

  assign pc4         = pc + WORD_BYTES;
  assign branch_addr = pc + immediate;

  always_comb begin
    case (branch_func)
      BR_BEQ:  branch_taken = (port_a == port_b);
      BR_BNE:  branch_taken = (port_a != port_b);
      BR_BLT:  branch_taken = ($signed(port_a) < $signed(port_b));
      BR_BGE:  branch_taken = ($signed(port_a) >= $signed(port_b));
      BR_BLTU: branch_taken = (port_a < port_b);
      BR_BGEU: branch_taken = (port_a >= port_b);
      default: branch_taken = 1'b0;
    endcase
  end

  // jalr is register relative, jal is pc relative
  assign jump_addr = jalr ? ((port_a + immediate) & JALR_ALIGN_MASK) : branch_addr;

  assign resolved_addr = branch_taken ? branch_addr : pc4;

  // predictor only guesses direction, jumps always redirect
  assign branch_mispredict = branch_instr & (prediction ^ branch_taken);
  assign mispredict        = jump_instr | branch_mispredict;

  always_comb begin
    if (jump_instr) begin
      brj_addr = jump_addr;
    end else if (branch_mispredict) begin
      brj_addr = resolved_addr;
    end else begin
      brj_addr = pc4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mispredict_ff <= 1'b0;
    end else begin
      mispredict_ff <= mispredict;
    end
  end

  // decode never issues both kinds at once
  assert property (@(posedge CLK) disable iff (!nRST) !(branch_instr && jump_instr))
    else $error("branch_instr and jump_instr both high");

endmodule

/* hw/csr_file.sv */
// local machine CSR file
// mstatus, mtvec, mscratch, mepc with swap/set/clear access
// one access per instruction through an edge detected pulse
module csr_file
  import rv32_isa_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      csr_instr,
  input  logic      csr_swap,
  input  logic      csr_set,
  input  logic      csr_clr,
  input  csr_addr_t csr_addr,
  input  word_t     csr_wdata,
  output word_t     csr_rdata,
  output logic      csr_hazard,
  output logic      invalid_csr
);

  word_t      csr_q [NUM_CSR];
  logic [1:0] csr_idx;
  logic       csr_valid;
  logic       csr_instr_q;
  word_t      live_rdata;
  word_t      rdata_q;
  word_t      csr_wval;
  logic       csr_wen;

  // address decode
  always_comb begin
    csr_idx   = 2'd0;
    csr_valid = 1'b1;
    case (csr_addr)
      CSR_MSTATUS:  csr_idx = 2'd0;
      CSR_MTVEC:    csr_idx = 2'd1;
      CSR_MSCRATCH: csr_idx = 2'd2;
      CSR_MEPC:     csr_idx = 2'd3;
      default:      csr_valid = 1'b0;
    endcase
  end

  assign invalid_csr = csr_instr & ~csr_valid;
  assign live_rdata  = csr_valid ? csr_q[csr_idx] : '0;

  // rising edge of csr_instr, held instructions only access once
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      csr_instr_q <= 1'b0;
    end else begin
      csr_instr_q <= csr_instr;
    end
  end

  assign csr_hazard = csr_instr & ~csr_instr_q;

  always_comb begin
    csr_wval = csr_wdata;
    if (csr_set) begin
      csr_wval = live_rdata | csr_wdata;
    end else if (csr_clr) begin
      csr_wval = live_rdata & ~csr_wdata;
    end
  end

  assign csr_wen = csr_hazard & csr_valid & (csr_swap | csr_set | csr_clr);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_CSR; i++) begin
        csr_q[i] <= '0;
      end
    end else if (csr_wen) begin
      csr_q[csr_idx] <= csr_wval;
    end
  end

  // keep the pre-write value for the rest of a held instruction
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rdata_q <= '0;
    end else if (csr_hazard) begin
      rdata_q <= live_rdata;
    end
  end

  assign csr_rdata = csr_hazard ? live_rdata : rdata_q;

  assert property (@(posedge CLK) disable iff (!nRST) $onehot0({csr_swap, csr_set, csr_clr}))
    else $error("more than one CSR access type selected");

endmodule

/* hw/ex_commit_latch.sv */
// execute to commit register
// flush/halt clear, stall_commit hold, stall_ex bubble, else load
// interrupt pending latch sampled into intr_seen
module ex_commit_latch
  import rv32_isa_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      halt,
  input  logic      execute_commit_flush,
  input  logic      stall_ex,
  input  logic      stall_commit,
  input  logic      intr,
  input  logic      intr_taken,
  input  word_t     alu_wdata,
  input  reg_addr_t reg_rd,
  input  logic      wen,
  input  word_t     pc,
  input  logic      jump_instr,
  input  logic      branch_instr,
  input  logic      branch_taken,
  input  logic      prediction,
  input  word_t     jump_addr,
  input  word_t     resolved_addr,
  input  logic      invalid_csr,
  input  logic      illegal_insn,
  input  logic      breakpoint,
  input  logic      ecall_insn,
  input  logic      halt_instr,
  output logic      wen_au,
  output reg_addr_t reg_rd_au,
  output word_t     wdata_au,
  output word_t     pc_c,
  output logic      jump_instr_c,
  output word_t     jump_addr_c,
  output logic      branch_instr_c,
  output logic      branch_taken_c,
  output logic      prediction_c,
  output word_t     br_resolved_addr,
  output logic      invalid_csr_c,
  output logic      illegal_insn_c,
  output logic      breakpoint_c,
  output logic      ecall_insn_c,
  output logic      intr_seen,
  output logic      halt_instr_c
);

  logic intr_pending;

  // interrupt stays pending while the core is busy
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      intr_pending <= 1'b0;
    end else if (halt) begin
      intr_pending <= 1'b0;
    end else if (intr) begin
      intr_pending <= 1'b1;
    end else if (intr_taken) begin
      intr_pending <= 1'b0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {wen_au, reg_rd_au, wdata_au, pc_c} <= '0;
      {jump_instr_c, jump_addr_c, branch_instr_c, branch_taken_c} <= '0;
      {prediction_c, br_resolved_addr, invalid_csr_c, illegal_insn_c} <= '0;
      {breakpoint_c, ecall_insn_c, intr_seen, halt_instr_c} <= '0;
    end else if (execute_commit_flush || halt) begin
      {wen_au, reg_rd_au, wdata_au, pc_c} <= '0;
      {jump_instr_c, jump_addr_c, branch_instr_c, branch_taken_c} <= '0;
      {prediction_c, br_resolved_addr, invalid_csr_c, illegal_insn_c} <= '0;
      {breakpoint_c, ecall_insn_c, intr_seen, halt_instr_c} <= '0;
    end else if (!stall_commit) begin
      if (stall_ex) begin
        // nothing issued this cycle
        wen_au           <= BUBBLE_FLAG;
        reg_rd_au        <= BUBBLE_REG_RD;
        wdata_au         <= BUBBLE_WORD;
        pc_c             <= BUBBLE_WORD;
        jump_instr_c     <= BUBBLE_FLAG;
        jump_addr_c      <= BUBBLE_WORD;
        branch_instr_c   <= BUBBLE_FLAG;
        branch_taken_c   <= BUBBLE_FLAG;
        prediction_c     <= BUBBLE_FLAG;
        br_resolved_addr <= BUBBLE_WORD;
        invalid_csr_c    <= BUBBLE_FLAG;
        illegal_insn_c   <= BUBBLE_FLAG;
        breakpoint_c     <= BUBBLE_FLAG;
        ecall_insn_c     <= BUBBLE_FLAG;
        intr_seen        <= BUBBLE_FLAG;
        halt_instr_c     <= BUBBLE_FLAG;
      end else begin
        wen_au           <= wen;
        reg_rd_au        <= reg_rd;
        wdata_au         <= alu_wdata;
        pc_c             <= pc;
        jump_instr_c     <= jump_instr;
        jump_addr_c      <= jump_addr;
        branch_instr_c   <= branch_instr;
        branch_taken_c   <= branch_taken;
        prediction_c     <= prediction;
        br_resolved_addr <= resolved_addr;
        invalid_csr_c    <= invalid_csr;
        illegal_insn_c   <= illegal_insn;
        breakpoint_c     <= breakpoint;
        ecall_insn_c     <= ecall_insn;
        intr_seen        <= intr_pending;
        halt_instr_c     <= halt_instr;
      end
    end
  end

  // a flushed slot never writes the register file
  assert property (@(posedge CLK) disable iff (!nRST) execute_commit_flush |=> !wen_au)
    else $error("wen_au high in the cycle after a flush");

endmodule

/* hw/ex_stage_top.sv */
// integer execute stage top level
// ALU, branch resolver, CSR file and execute-commit register
module ex_stage_top
  import rv32_isa_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         halt,
  input  logic         execute_commit_flush,
  input  logic         stall_ex,
  input  logic         stall_commit,
  input  logic         intr,
  input  logic         intr_taken,
  input  word_t        port_a,
  input  word_t        port_b,
  input  word_t        immediate,
  input  word_t        pc,
  input  alu_op_t      alu_op,
  input  result_src_t  result_src,
  input  reg_addr_t    reg_rd,
  input  logic         wen,
  input  logic         branch_instr,
  input  branch_func_t branch_func,
  input  logic         prediction,
  input  logic         jump_instr,
  input  logic         jalr,
  input  logic         csr_instr,
  input  logic         csr_swap,
  input  logic         csr_set,
  input  logic         csr_clr,
  input  csr_addr_t    csr_addr,
  input  word_t        csr_wdata,
  input  logic         illegal_insn,
  input  logic         breakpoint,
  input  logic         ecall_insn,
  input  logic         halt_instr,
  output logic         mispredict,
  output logic         mispredict_ff,
  output word_t        brj_addr,
  output logic         csr_hazard,
  output logic         wen_au,
  output reg_addr_t    reg_rd_au,
  output word_t        wdata_au,
  output word_t        pc_c,
  output logic         jump_instr_c,
  output word_t        jump_addr_c,
  output logic         branch_instr_c,
  output logic         branch_taken_c,
  output logic         prediction_c,
  output word_t        br_resolved_addr,
  output logic         invalid_csr_c,
  output logic         illegal_insn_c,
  output logic         breakpoint_c,
  output logic         ecall_insn_c,
  output logic         intr_seen,
  output logic         halt_instr_c
);

  word_t alu_wdata;
  word_t csr_rdata;
  logic  invalid_csr;
  logic  branch_taken;
  word_t resolved_addr;
  word_t jump_addr;

  alu_unit u_alu (
    .port_a     (port_a),
    .port_b     (port_b),
    .pc         (pc),
    .alu_op     (alu_op),
    .result_src (result_src),
    .csr_rdata  (csr_rdata),
    .alu_wdata  (alu_wdata)
  );

  branch_resolver u_bres (
    .CLK           (CLK),
    .nRST          (nRST),
    .port_a        (port_a),
    .port_b        (port_b),
    .immediate     (immediate),
    .pc            (pc),
    .branch_instr  (branch_instr),
    .branch_func   (branch_func),
    .prediction    (prediction),
    .jump_instr    (jump_instr),
    .jalr          (jalr),
    .branch_taken  (branch_taken),
    .mispredict    (mispredict),
    .mispredict_ff (mispredict_ff),
    .resolved_addr (resolved_addr),
    .jump_addr     (jump_addr),
    .brj_addr      (brj_addr)
  );

  csr_file u_csr (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_instr   (csr_instr),
    .csr_swap    (csr_swap),
    .csr_set     (csr_set),
    .csr_clr     (csr_clr),
    .csr_addr    (csr_addr),
    .csr_wdata   (csr_wdata),
    .csr_rdata   (csr_rdata),
    .csr_hazard  (csr_hazard),
    .invalid_csr (invalid_csr)
  );

  ex_commit_latch u_commit (
    .CLK                  (CLK),
    .nRST                 (nRST),
    .halt                 (halt),
    .execute_commit_flush (execute_commit_flush),
    .stall_ex             (stall_ex),
    .stall_commit         (stall_commit),
    .intr                 (intr),
    .intr_taken           (intr_taken),
    .alu_wdata            (alu_wdata),
    .reg_rd               (reg_rd),
    .wen                  (wen),
    .pc                   (pc),
    .jump_instr           (jump_instr),
    .branch_instr         (branch_instr),
    .branch_taken         (branch_taken),
    .prediction           (prediction),
    .jump_addr            (jump_addr),
    .resolved_addr        (resolved_addr),
    .invalid_csr          (invalid_csr),
    .illegal_insn         (illegal_insn),
    .breakpoint           (breakpoint),
    .ecall_insn           (ecall_insn),
    .halt_instr           (halt_instr),
    .wen_au               (wen_au),
    .reg_rd_au            (reg_rd_au),
    .wdata_au             (wdata_au),
    .pc_c                 (pc_c),
    .jump_instr_c         (jump_instr_c),
    .jump_addr_c          (jump_addr_c),
    .branch_instr_c       (branch_instr_c),
    .branch_taken_c       (branch_taken_c),
    .prediction_c         (prediction_c),
    .br_resolved_addr     (br_resolved_addr),
    .invalid_csr_c        (invalid_csr_c),
    .illegal_insn_c       (illegal_insn_c),
    .breakpoint_c         (breakpoint_c),
    .ecall_insn_c         (ecall_insn_c),
    .intr_seen            (intr_seen),
    .halt_instr_c         (halt_instr_c)
  );

endmodule

/* dv/ex_stage_tb.sv */
// testbench for the integer execute stage
// random and directed stimulus, reference model of CSRs and commit register
// concurrent checks on redirect, CSR and commit outputs, watchdog
module ex_stage_tb
  import rv32_isa_pkg::*;
  import ex_pipe_pkg::*;
();

  localparam int          CLK_PERIOD   = 20;
  localparam int          NUM_RANDOM   = 400;
  localparam int          NUM_DIRECTED = 120;
  localparam int unsigned SEED         = 32'h5e9d_29c2;
  localparam int          GRP_REDIRECT = 0;
  localparam int          GRP_COMMIT   = 1;
  localparam int          GRP_CSR      = 2;
  localparam csr_addr_t   CSR_UNUSED   = 12'h7c0;

  // expected contents of the execute-commit register
  typedef struct packed {
    logic      wen;
    reg_addr_t reg_rd;
    word_t     wdata;
    word_t     pc;
    logic      jump_instr;
    word_t     jump_addr;
    logic      branch_instr;
    logic      branch_taken;
    logic      prediction;
    word_t     resolved_addr;
    logic      invalid_csr;
    logic      illegal_insn;
    logic      breakpoint;
    logic      ecall_insn;
    logic      intr_seen;
    logic      halt_instr;
  } commit_t;

  logic         CLK;
  logic         nRST;
  logic         halt;
  logic         execute_commit_flush;
  logic         stall_ex;
  logic         stall_commit;
  logic         intr;
  logic         intr_taken;
  word_t        port_a;
  word_t        port_b;
  word_t        immediate;
  word_t        pc;
  alu_op_t      alu_op;
  result_src_t  result_src;
  reg_addr_t    reg_rd;
  logic         wen;
  logic         branch_instr;
  branch_func_t branch_func;
  logic         prediction;
  logic         jump_instr;
  logic         jalr;
  logic         csr_instr;
  logic         csr_swap;
  logic         csr_set;
  logic         csr_clr;
  csr_addr_t    csr_addr;
  word_t        csr_wdata;
  logic         illegal_insn;
  logic         breakpoint;
  logic         ecall_insn;
  logic         halt_instr;
  logic         mispredict;
  logic         mispredict_ff;
  word_t        brj_addr;
  logic         csr_hazard;
  logic         wen_au;
  reg_addr_t    reg_rd_au;
  word_t        wdata_au;
  word_t        pc_c;
  logic         jump_instr_c;
  word_t        jump_addr_c;
  logic         branch_instr_c;
  logic         branch_taken_c;
  logic         prediction_c;
  word_t        br_resolved_addr;
  logic         invalid_csr_c;
  logic         illegal_insn_c;
  logic         breakpoint_c;
  logic         ecall_insn_c;
  logic         intr_seen;
  logic         halt_instr_c;

  // reference model state
  commit_t     m_commit        = '0;
  logic        m_mispredict_ff = 1'b0;
  logic        m_intr_pending  = 1'b0;
  logic        m_csr_instr_q   = 1'b0;
  word_t       m_csr_old       = '0;
  word_t       m_csr [NUM_CSR] = '{default: '0};

  // expectations for the current issue cycle
  logic        exp_taken;
  logic        exp_mispredict;
  logic        exp_hazard;
  logic        exp_invalid;
  word_t       exp_resolved;
  word_t       exp_jump_addr;
  word_t       exp_brj;
  word_t       exp_live_old;
  word_t       exp_wdata;

  int          errors [3] = '{default: 0};
  int          total_errors;
  int unsigned seed_val;

  csr_addr_t    csr_addrs [NUM_CSR] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC};
  branch_func_t br_funcs [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

  ex_stage_top u_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic flag_error(input int group, input string msg);
    $display("CHECK FAILED @ %0t: %s", $time, msg);
    errors[group]++;
  endtask

  function automatic int csr_slot(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:  return 0;
      CSR_MTVEC:    return 1;
      CSR_MSCRATCH: return 2;
      CSR_MEPC:     return 3;
      default:      return -1;
    endcase
  endfunction

  function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
    int    sh;
    word_t fill;
    sh   = int'(b[4:0]);
    // sign bits shifted in by an arithmetic right shift
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      // differing signs decide, else an unsigned compare
      ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      ALU_SLTU: return {31'b0, a < b};
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | fill;
      default:  return '0;
    endcase
  endfunction

  function automatic logic taken_ref(input branch_func_t f, input word_t a, input word_t b);
    case (f)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return $signed(a) < $signed(b);
      BR_BGE:  return !($signed(a) < $signed(b));
      BR_BLTU: return a < b;
      BR_BGEU: return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  task automatic clear_inputs();
    {halt, execute_commit_flush, stall_ex, stall_commit, intr, intr_taken} = '0;
    {port_a, port_b, immediate, pc, csr_wdata} = '0;
    {reg_rd, wen, branch_instr, prediction, jump_instr, jalr} = '0;
    {csr_instr, csr_swap, csr_set, csr_clr, csr_addr} = '0;
    {illegal_insn, breakpoint, ecall_insn, halt_instr} = '0;
    alu_op      = ALU_ADD;
    result_src  = SRC_ALU;
    branch_func = BR_BEQ;
  endtask

  // one random instruction, optionally with random pipeline controls
  task automatic random_instr(input bit with_ctrl);
    int    kind;
    word_t r;
    clear_inputs();
    kind      = $urandom_range(0, 9);
    r         = $urandom;
    port_a    = $urandom;
    // equal operands now and then so beq/bge take
    port_b    = (r[31:29] == 3'd0) ? port_a : $urandom;
    immediate = $urandom;
    pc        = $urandom & 32'hffff_fffc;
    alu_op    = alu_op_t'($urandom_range(0, 9));
    reg_rd    = r[4:0];
    wen       = 1'b1;
    if (kind == 5 || kind == 6) begin
      branch_instr = 1'b1;
      branch_func  = br_funcs[$urandom_range(0, 5)];
      prediction   = r[8];
      wen          = 1'b0;
    end else if (kind == 7) begin
      jump_instr = 1'b1;
      jalr       = r[9];
      result_src = SRC_LINK;
    end else if (kind == 8) begin
      csr_instr  = 1'b1;
      {csr_swap, csr_set, csr_clr} = 3'b001 << $urandom_range(0, 2);
      csr_addr   = (r[12:10] == 3'd0) ? CSR_UNUSED : csr_addrs[$urandom_range(0, 3)];
      csr_wdata  = $urandom;
      result_src = SRC_CSR;
    end else if (kind == 9) begin
      {illegal_insn, breakpoint, ecall_insn, halt_instr} = r[16:13];
    end
    if (with_ctrl) begin
      stall_ex             = ($urandom_range(0, 9) == 0);
      stall_commit         = ($urandom_range(0, 11) == 0);
      execute_commit_flush = ($urandom_range(0, 15) == 0);
      halt                 = ($urandom_range(0, 39) == 0);
      intr                 = ($urandom_range(0, 19) == 0);
      intr_taken           = ($urandom_range(0, 14) == 0);
    end
  endtask

  // same-cycle expectations from the inputs and the model state
  task automatic compute_expected();
    word_t sum;
    int    slot;
    slot           = csr_slot(csr_addr);
    sum            = port_a + immediate;
    exp_taken      = taken_ref(branch_func, port_a, port_b);
    exp_resolved   = exp_taken ? pc + immediate : pc + 32'd4;
    exp_jump_addr  = jalr ? {sum[31:1], 1'b0} : pc + immediate;
    exp_mispredict = jump_instr | (branch_instr & (prediction ^ exp_taken));
    if (jump_instr) begin
      exp_brj = exp_jump_addr;
    end else if (exp_mispredict) begin
      exp_brj = exp_resolved;
    end else begin
      exp_brj = pc + 32'd4;
    end
    exp_hazard   = csr_instr & ~m_csr_instr_q;
    exp_invalid  = csr_instr & (slot < 0);
    exp_live_old = '0;
    if (slot >= 0) begin
      exp_live_old = m_csr[slot];
    end
    case (result_src)
      SRC_LINK: exp_wdata = pc + 32'd4;
      SRC_CSR:  exp_wdata = exp_hazard ? exp_live_old : m_csr_old;
      default:  exp_wdata = alu_ref(alu_op, port_a, port_b);
    endcase
  endtask

  // apply the clock edge that ended the current issue cycle
  task automatic step_model();
    commit_t nxt;
    int      slot;
    slot = csr_slot(csr_addr);
    nxt  = m_commit;
    if (execute_commit_flush || halt) begin
      nxt = '0;
    end else if (!stall_commit && stall_ex) begin
      nxt = '0;
    end else if (!stall_commit) begin
      nxt = {wen, reg_rd, exp_wdata, pc, jump_instr, exp_jump_addr, branch_instr,
             exp_taken, prediction, exp_resolved, exp_invalid, illegal_insn,
             breakpoint, ecall_insn, m_intr_pending, halt_instr};
    end
    m_commit        = nxt;
    m_mispredict_ff = exp_mispredict;
    if (halt) begin
      m_intr_pending = 1'b0;
    end else if (intr) begin
      m_intr_pending = 1'b1;
    end else if (intr_taken) begin
      m_intr_pending = 1'b0;
    end
    if (exp_hazard) begin
      m_csr_old = exp_live_old;
      if (slot >= 0 && csr_swap) begin
        m_csr[slot] = csr_wdata;
      end else if (slot >= 0 && csr_set) begin
        m_csr[slot] = m_csr[slot] | csr_wdata;
      end else if (slot >= 0 && csr_clr) begin
        m_csr[slot] = m_csr[slot] & ~csr_wdata;
      end
    end
    m_csr_instr_q = csr_instr;
  endtask

  task automatic issue();
    compute_expected();
    @(posedge CLK);
    @(negedge CLK);
    step_model();
  endtask

  // csr_instr held for hold cycles, stall_ex on all but the last
  task automatic csr_access(input logic [2:0] op, input csr_addr_t addr,
                            input word_t data, input int hold);
    for (int i = 0; i < hold; i++) begin
      clear_inputs();
      csr_instr  = 1'b1;
      {csr_swap, csr_set, csr_clr} = op;
      csr_addr   = addr;
      csr_wdata  = data;
      result_src = SRC_CSR;
      wen        = 1'b1;
      reg_rd     = 5'd10;
      pc         = 32'h0000_2000;
      stall_ex   = (i < hold - 1);
      issue();
    end
    clear_inputs();
    issue();
  endtask

  task automatic control_sequence();
    random_instr(1'b0);
    issue();
    repeat (2) begin
      random_instr(1'b0);
      stall_commit = 1'b1;
      issue();
    end
    random_instr(1'b0);
    stall_ex = 1'b1;
    issue();
    random_instr(1'b0);
    issue();
    random_instr(1'b0);
    execute_commit_flush = 1'b1;
    issue();
    random_instr(1'b0);
    issue();
    random_instr(1'b0);
    halt = 1'b1;
    issue();
  endtask

  task automatic intr_sequence();
    random_instr(1'b0);
    intr = 1'b1;
    issue();
    repeat (3) begin
      random_instr(1'b0);
      issue();
    end
    random_instr(1'b0);
    intr_taken = 1'b1;
    issue();
    repeat (2) begin
      random_instr(1'b0);
      issue();
    end
    random_instr(1'b0);
    intr = 1'b1;
    issue();
    repeat (2) begin
      random_instr(1'b0);
      issue();
    end
    random_instr(1'b0);
    halt = 1'b1;
    issue();
    repeat (2) begin
      random_instr(1'b0);
      issue();
    end
  endtask

  // redirect, same cycle and one clock later
  assert property (@(posedge CLK) disable iff (!nRST) mispredict == exp_mispredict)
    else flag_error(GRP_REDIRECT, "mispredict differs from model");
  assert property (@(posedge CLK) disable iff (!nRST) brj_addr == exp_brj)
    else flag_error(GRP_REDIRECT, $sformatf("brj_addr %h, expected %h",
                                            $sampled(brj_addr), $sampled(exp_brj)));
  assert property (@(posedge CLK) disable iff (!nRST) mispredict_ff == m_mispredict_ff)
    else flag_error(GRP_REDIRECT, "mispredict_ff differs from model");

  // CSR access pulse and invalid address
  assert property (@(posedge CLK) disable iff (!nRST) csr_hazard == exp_hazard)
    else flag_error(GRP_CSR, "csr_hazard differs from model");
  assert property (@(posedge CLK) disable iff (!nRST) invalid_csr_c == m_commit.invalid_csr)
    else flag_error(GRP_CSR, "invalid_csr_c differs from model");

  // commit register contents
  assert property (@(posedge CLK) disable iff (!nRST)
                   {wen_au, reg_rd_au} == {m_commit.wen, m_commit.reg_rd})
    else flag_error(GRP_COMMIT, "wen_au or reg_rd_au differs from model");
  assert property (@(posedge CLK) disable iff (!nRST) wdata_au == m_commit.wdata)
    else flag_error(GRP_COMMIT, $sformatf("wdata_au %h, expected %h",
                                          $sampled(wdata_au), $sampled(m_commit.wdata)));
  assert property (@(posedge CLK) disable iff (!nRST) pc_c == m_commit.pc)
    else flag_error(GRP_COMMIT, "pc_c differs from model");
  assert property (@(posedge CLK) disable iff (!nRST)
                   {jump_instr_c, jump_addr_c} == {m_commit.jump_instr, m_commit.jump_addr})
    else flag_error(GRP_COMMIT, "jump fields differ from model");
  assert property (@(posedge CLK) disable iff (!nRST)
                   {branch_instr_c, branch_taken_c, prediction_c, br_resolved_addr} ==
                   {m_commit.branch_instr, m_commit.branch_taken, m_commit.prediction,
                    m_commit.resolved_addr})
    else flag_error(GRP_COMMIT, "branch fields differ from model");
  assert property (@(posedge CLK) disable iff (!nRST)
                   {illegal_insn_c, breakpoint_c, ecall_insn_c, halt_instr_c} ==
                   {m_commit.illegal_insn, m_commit.breakpoint, m_commit.ecall_insn,
                    m_commit.halt_instr})
    else flag_error(GRP_COMMIT, "exception flags differ from model");
  assert property (@(posedge CLK) disable iff (!nRST) intr_seen == m_commit.intr_seen)
    else flag_error(GRP_COMMIT, "intr_seen differs from model");

  initial begin
    seed_val = $urandom(SEED);
    nRST     = 1'b0;
    clear_inputs();
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      random_instr(1'b1);
      issue();
    end
    // swap, set, clear, then read back each CSR
    for (int s = 0; s < NUM_CSR; s++) begin
      csr_access(3'b100, csr_addrs[s], 32'ha5c3_0000 | (32'h11 << s), 3);
      csr_access(3'b010, csr_addrs[s], 32'h0f0f_00f0, 2);
      csr_access(3'b001, csr_addrs[s], 32'h0003_0011, 2);
      csr_access(3'b010, csr_addrs[s], 32'h0, 1);
    end
    csr_access(3'b100, CSR_UNUSED, 32'hdead_beef, 2);
    for (int s = 0; s < NUM_CSR; s++) begin
      csr_access(3'b010, csr_addrs[s], 32'h0, 1);
    end
    repeat (3) control_sequence();
    intr_sequence();
    clear_inputs();
    repeat (2) issue();
    total_errors = errors[GRP_REDIRECT] + errors[GRP_COMMIT] + errors[GRP_CSR];
    $display("errors: redirect %0d, commit %0d, csr %0d, total %0d",
             errors[GRP_REDIRECT], errors[GRP_COMMIT], errors[GRP_CSR], total_errors);
    if (total_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog sized from the instruction count
  initial begin
    #((NUM_RANDOM + NUM_DIRECTED + 100) * CLK_PERIOD);
    $display("timeout: stimulus did not finish within %0d cycles",
             NUM_RANDOM + NUM_DIRECTED + 100);
    $display("sim failed");
    $finish;
  end

endmodule

/* build.f */
hw/rv32_isa_pkg.sv
hw/ex_pipe_pkg.sv
hw/alu_unit.sv
hw/branch_resolver.sv
hw/csr_file.sv
hw/ex_commit_latch.sv
hw/ex_stage_top.sv
dv/ex_stage_tb.sv
